// ==== dds_sine.sv ====
`default_nettype none

module dds_sine (
  input  logic                clk125,
  input  logic                areset_n,
  input  imp_pkg::phase_inc_t phase_inc,
  output imp_pkg::sample_t    dac
);
  import imp_pkg::*;

  phase_inc_t acc;
  logic [1:0] quad;
  logic [3:0] addr;
  logic [3:0] lut_addr;
  sample_t    amp;  // quarter-wave magnitude, never zero

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
      acc <= '0;
    else
      acc <= acc + phase_inc;  // wraps at one full period
  end

  assign quad     = acc[31:30];
  assign addr     = acc[29:26];
  assign lut_addr = quad[0] ? ~addr : addr;  // 2nd and 4th quarter read backwards

  // 8000 * sin((i + 0.5) * pi / 32), half-step offset keeps the sign clean
  always_comb
  begin
    case (lut_addr)
      4'd0:    amp = 14'sd393;
      4'd1:    amp = 14'sd1174;
      4'd2:    amp = 14'sd1944;
      4'd3:    amp = 14'sd2695;
      4'd4:    amp = 14'sd3420;
      4'd5:    amp = 14'sd4113;
      4'd6:    amp = 14'sd4766;
      4'd7:    amp = 14'sd5372;
      4'd8:    amp = 14'sd5928;
      4'd9:    amp = 14'sd6426;
      4'd10:   amp = 14'sd6862;
      4'd11:   amp = 14'sd7232;
      4'd12:   amp = 14'sd7532;
      4'd13:   amp = 14'sd7760;
      4'd14:   amp = 14'sd7913;
      default: amp = 14'sd7990;  // peak
    endcase
  end

  always_ff @(posedge clk125)
    dac <= quad[1] ? -amp : amp;  // second half-period negative

endmodule

`default_nettype wire

// ==== freq_table.hex ====
// one 32-bit dds phase increment per sweep point, point 0 first
// period in clocks after each word, slowest point first
02000000  // 128
02222222  // 120
02492492  // 112
028F5C29  // 100
02AAAAAB  // 96
02E8BA2F  // 88
03333333  // 80
038E38E4  // 72
04000000  // 64
04924925  // 56
051EB852  // 50
05555555  // 48
05D1745D  // 44
06666666  // 40
071C71C7  // 36
08000000  // 32

// ==== imp_pkg.sv ====
`default_nettype none

package imp_pkg;

  localparam int sample_w = 14;  // adc and dac sample width
  typedef logic signed [sample_w-1:0] sample_t;

  localparam int data_w = 32;  // results, accumulators
  typedef logic signed [data_w-1:0] result_t;

  typedef logic [31:0] phase_inc_t;  // dds step and phase accumulator

  localparam int num_points = 16;
  typedef logic [$clog2(num_points)-1:0] point_t;
  localparam string freq_file = "freq_table.hex";  // one phase increment per point

  // window lengths, all stored minus one
  localparam int det_width     = 10;  // non-negative run before a crossing
  localparam int settle_cycles = 4;   // stimulus periods before each point
  localparam int meas_cycles   = 4;   // crossing pairs per measurement
  typedef logic [2:0] cycle_cnt_t;    // reaches meas_cycles+1

  localparam int shunt = 1000;  // ratio in parts per thousand

  typedef enum logic [1:0] {
    sw_idle,
    sw_settle,
    sw_measure,
    sw_done
  } sweep_state_t;

  typedef enum logic [2:0] {
    ms_idle,
    ms_align,    // counting the first crossing pairs
    ms_a_leads,
    ms_b_leads,
    ms_aligned
  } meas_state_t;

endpackage

`default_nettype wire

// ==== impedance_sweep_top.sv ====
`default_nettype none

module impedance_sweep_top (
  input  logic                clk125,
  input  logic                areset_n,
  input  logic                start,
  input  imp_pkg::sample_t    adc_a,
  input  imp_pkg::sample_t    adc_b,
  output imp_pkg::sample_t    dac_out,
  output imp_pkg::phase_inc_t phase_inc,
  output logic                sweep_done,
  output imp_pkg::result_t    magnitude,
  output imp_pkg::result_t    phase,
  output imp_pkg::point_t     result_index,
  output logic                mag_valid
);
  import imp_pkg::*;

  sample_t dds_sample;  // raw dds output
  sample_t sample_a;
  sample_t sample_b;
  logic    stim_cross;
  logic    cross_a;
  logic    cross_b;

  meas_if meas_bus ();

  dds_sine u_dds (
    .clk125    (clk125),
    .areset_n  (areset_n),
    .phase_inc (phase_inc),
    .dac       (dds_sample)
  );

  // stimulus path shares the detector latency of both adc channels
  zero_cross_det u_det_s (
    .clk125   (clk125),
    .areset_n (areset_n),
    .sample   (dds_sample),
    .sample_q (dac_out),
    .crossing (stim_cross)
  );

  zero_cross_det u_det_a (
    .clk125   (clk125),
    .areset_n (areset_n),
    .sample   (adc_a),
    .sample_q (sample_a),
    .crossing (cross_a)
  );

  zero_cross_det u_det_b (
    .clk125   (clk125),
    .areset_n (areset_n),
    .sample   (adc_b),
    .sample_q (sample_b),
    .crossing (cross_b)
  );

  sweep_ctrl u_sweep (
    .clk125        (clk125),
    .areset_n      (areset_n),
    .start         (start),
    .stim_crossing (stim_cross),
    .phase_inc     (phase_inc),
    .sweep_done    (sweep_done),
    .meas          (meas_bus)
  );

  measure_engine u_engine (
    .clk125       (clk125),
    .areset_n     (areset_n),
    .sample_a     (sample_a),
    .sample_b     (sample_b),
    .cross_a      (cross_a),
    .cross_b      (cross_b),
    .meas         (meas_bus),
    .magnitude    (magnitude),
    .phase        (phase),
    .result_index (result_index),
    .mag_valid    (mag_valid)
  );

endmodule

`default_nettype wire

// ==== meas_if.sv ====
`default_nettype none

interface meas_if;
  import imp_pkg::*;

  logic   start;  // one-cycle request
  point_t index;  // point under test, valid with start
  logic   done;   // window closed
  logic   idle;   // engine free

  modport ctrl (
    output start,
    output index,
    input  done,
    input  idle
  );

  modport engine (
    input  start,
    input  index,
    output done,
    output idle
  );

endinterface

`default_nettype wire

// ==== measure_engine.sv ====
`default_nettype none

module measure_engine (
  input  logic             clk125,
  input  logic             areset_n,
  input  imp_pkg::sample_t sample_a,
  input  imp_pkg::sample_t sample_b,
  input  logic             cross_a,
  input  logic             cross_b,
  meas_if.engine           meas,
  output imp_pkg::result_t magnitude,
  output imp_pkg::result_t phase,
  output imp_pkg::point_t  result_index,
  output logic             mag_valid
);
  import imp_pkg::*;

  meas_state_t state;
  cycle_cnt_t  cnt_a;
  cycle_cnt_t  cnt_b;
  cycle_cnt_t  next_a;
  cycle_cnt_t  next_b;
  sample_t     max_a;
  sample_t     min_a;
  sample_t     max_b;
  sample_t     min_b;
  result_t     phase_cnt;  // cycles since the leading crossing
  result_t     pp_a;       // quarter peak-to-peak
  result_t     pp_b;
  result_t     quotient;
  result_t     phase_hold;
  point_t      req_index;
  point_t      index_hold;
  logic        leading;
  logic        lead_cross;
  logic        lead_seen;
  logic        pair_full;
  logic        win_done;
  logic        done_q;
  logic        div_done;

  assign next_a = cnt_a + cycle_cnt_t'(cross_a);
  assign next_b = cnt_b + cycle_cnt_t'(cross_b);
  assign pair_full = (cross_a || cross_b) && next_a == cycle_cnt_t'(meas_cycles) &&
                     next_b == cycle_cnt_t'(meas_cycles);
  assign win_done = (state == ms_a_leads || state == ms_b_leads || state == ms_aligned) &&
                    next_a == cycle_cnt_t'(meas_cycles + 1) &&
                    next_b == cycle_cnt_t'(meas_cycles + 1);

  assign leading    = (state == ms_a_leads) || (state == ms_b_leads);
  assign lead_cross = leading && ((state == ms_a_leads) ? cross_a : cross_b);
  assign lead_seen  = leading && (((state == ms_a_leads) ? cnt_a : cnt_b) ==
                                  cycle_cnt_t'(meas_cycles + 1));

  assign pp_a = (result_t'(max_a) - result_t'(min_a)) >>> 2;
  assign pp_b = (result_t'(max_b) - result_t'(min_b)) >>> 2;

  assign meas.idle = (state == ms_idle);
  assign meas.done = done_q;

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state  <= ms_idle;
      cnt_a  <= '0;
      cnt_b  <= '0;
      done_q <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state)
        ms_idle:
          if (meas.start)
          begin
            cnt_a <= cycle_cnt_t'(cross_a);  // crossing in the request cycle counts
            cnt_b <= cycle_cnt_t'(cross_b);
            state <= ms_align;
          end
        ms_align:
        begin
          cnt_a <= next_a;
          cnt_b <= next_b;
          if (pair_full)  // whoever got there first leads
            if (cross_a && cross_b)
              state <= ms_aligned;
            else if (cross_b)
              state <= ms_a_leads;
            else
              state <= ms_b_leads;
        end
        ms_a_leads, ms_b_leads, ms_aligned:
        begin
          cnt_a <= next_a;
          cnt_b <= next_b;
          if (win_done)
          begin
            done_q <= 1'b1;  // also kicks the divider
            state  <= ms_idle;
          end
        end
        default:
          state <= ms_idle;
      endcase
    end
  end

  always_ff @(posedge clk125)
  begin
    if (meas.idle && meas.start)
    begin
      max_a     <= '0;
      min_a     <= '0;
      max_b     <= '0;
      min_b     <= '0;
      phase_cnt <= '0;
      req_index <= meas.index;  // index rides along with the request
    end
    else if (!meas.idle)
    begin
      if (sample_a > max_a)
        max_a <= sample_a;
      if (sample_a < min_a)
        min_a <= sample_a;
      if (sample_b > max_b)
        max_b <= sample_b;
      if (sample_b < min_b)
        min_b <= sample_b;
      if (lead_cross)
        phase_cnt <= result_t'(1);
      else if (lead_seen)
        phase_cnt <= phase_cnt + 1'b1;
      if (win_done)
      begin
        // positive when a leads, zero when both cross together
        phase_hold <= (state == ms_a_leads) ? phase_cnt :
                      (state == ms_b_leads) ? -phase_cnt : '0;
        index_hold <= req_index;
      end
    end
  end

  seq_divider #(
    .width (data_w)
  ) u_div (
    .clk125   (clk125),
    .areset_n (areset_n),
    .start    (done_q),
    .num      (pp_a * result_t'(shunt)),
    .den      (pp_b),
    .quotient (quotient),
    .done     (div_done)
  );

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
      mag_valid <= 1'b0;
    else
      mag_valid <= div_done;
  end

  always_ff @(posedge clk125)
  begin
    if (div_done)
    begin
      magnitude    <= quotient - result_t'(shunt);  // ratio above unity
      phase        <= phase_hold;
      result_index <= index_hold;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the impedance sweep testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_impedance \
  -f sources.f --Mdir obj_dir -o tb_impedance_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_impedance_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== seq_divider.sv ====
`default_nettype none

module seq_divider #(
  parameter int width = imp_pkg::data_w
) (
  input  logic                    clk125,
  input  logic                    areset_n,
  input  logic                    start,
  input  logic signed [width-1:0] num,
  input  logic signed [width-1:0] den,
  output logic signed [width-1:0] quotient,
  output logic                    done
);

  localparam int cnt_w = $clog2(width + 1);

  logic [cnt_w-1:0] step;  // quotient bits produced so far
  logic             busy;
  logic             last;
  logic             neg;
  logic             den_zero;
  logic [width-1:0] dvd;  // dividend out at the top, quotient bits in at the bottom
  logic [width-1:0] dvs;
  logic [width-1:0] rem;
  logic [width:0]   trial;

  assign last  = (step == cnt_w'(width));
  assign trial = {rem, dvd[width-1]} - {1'b0, dvs};

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      busy <= 1'b0;
      step <= '0;
      done <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        busy <= 1'b1;
        step <= '0;
      end
      else if (busy)
        if (last)
        begin
          busy <= 1'b0;
          done <= 1'b1;  // width+2 cycles after start
        end
        else
          step <= step + 1'b1;
    end
  end

  always_ff @(posedge clk125)
  begin
    if (start)
    begin
      dvd      <= num[width-1] ? -num : num;  // unsigned magnitudes
      dvs      <= den[width-1] ? -den : den;
      rem      <= '0;
      neg      <= num[width-1] ^ den[width-1];
      den_zero <= (den == '0);
    end
    else if (busy && !last)
    begin
      if (trial[width])  // negative, keep the old remainder
      begin
        rem <= {rem[width-2:0], dvd[width-1]};
        dvd <= {dvd[width-2:0], 1'b0};
      end
      else
      begin
        rem <= trial[width-1:0];
        dvd <= {dvd[width-2:0], 1'b1};
      end
    end
    else if (busy)
      quotient <= den_zero ? '0 : (neg ? -dvd : dvd);  // sign back on
  end

endmodule

`default_nettype wire

// ==== sources.f ====
imp_pkg.sv
meas_if.sv
zero_cross_det.sv
dds_sine.sv
seq_divider.sv
sweep_ctrl.sv
measure_engine.sv
impedance_sweep_top.sv
tb_impedance_chk.sv
tb_impedance.sv

// ==== sweep_ctrl.sv ====
`default_nettype none

module sweep_ctrl (
  input  logic                clk125,
  input  logic                areset_n,
  input  logic                start,
  input  logic                stim_crossing,
  output imp_pkg::phase_inc_t phase_inc,
  output logic                sweep_done,
  meas_if.ctrl                meas
);
  import imp_pkg::*;

  phase_inc_t   freq_rom [num_points];
  sweep_state_t state;
  point_t       index;
  cycle_cnt_t   settle_cnt;  // stimulus crossings seen this point
  logic         settled;

  initial
  begin
    $readmemh(freq_file, freq_rom);
  end

  assign phase_inc  = freq_rom[index];  // follows the index directly
  assign meas.index = index;            // stable for the whole point
  assign sweep_done = (state == sw_done);

  // last settle crossing, only while the engine can take a request
  assign settled = stim_crossing && meas.idle &&
                   (settle_cnt == cycle_cnt_t'(settle_cycles));

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state      <= sw_idle;
      index      <= '0;
      settle_cnt <= '0;
      meas.start <= 1'b0;
    end
    else
    begin
      meas.start <= 1'b0;
      case (state)
        sw_idle:
          if (start)
          begin
            settle_cnt <= '0;
            state      <= sw_settle;
          end
        sw_settle:
          if (settled)
          begin
            meas.start <= 1'b1;  // request goes out on a stimulus crossing
            state      <= sw_measure;
          end
          else if (stim_crossing && settle_cnt != cycle_cnt_t'(settle_cycles))
            settle_cnt <= settle_cnt + 1'b1;
        sw_measure:
          if (meas.done)
          begin
            settle_cnt <= '0;
            if (index == point_t'(num_points - 1))
              state <= sw_done;  // table exhausted
            else
            begin
              index <= index + 1'b1;
              state <= sw_settle;
            end
          end
        sw_done:
          if (!start)
          begin
            index <= '0;  // next sweep from point 0
            state <= sw_idle;
          end
        default:
          state <= sw_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tb_impedance.sv ====
`default_nettype none

module tb_impedance;
  import imp_pkg::*;

  localparam int num_sweeps  = 3;
  localparam int div_latency = data_w + 2;

  logic       clk125;
  logic       areset_n = 1'b0;
  logic       start = 1'b0;
  sample_t    adc_a = '0;
  sample_t    adc_b = '0;
  sample_t    dac_out;
  phase_inc_t phase_inc;
  logic       sweep_done;
  result_t    magnitude;
  result_t    phase;
  point_t     result_index;
  logic       mag_valid;

  phase_inc_t freq_model [num_points];  // own copy of the sweep table
  phase_inc_t seen_inc [$];             // phase_inc values in order of appearance
  sample_t    dly [8];                  // dac history for the loopback
  logic [2:0] d_a = '0;                 // channel a delay
  logic [2:0] d_b = '0;
  logic [1:0] k = '0;                   // channel b attenuation, shift right
  phase_inc_t acc_model = '0;           // stimulus phase, stepped by phase_inc
  logic [1:0] sign_pipe = '0;           // dds register, then detector register
  logic [31:0] rng;
  int         results;   // mag_valid pulses this sweep
  int         cycles = 0;
  int         limit = 0;

  impedance_sweep_top dut0 (
    .clk125       (clk125),
    .areset_n     (areset_n),
    .start        (start),
    .adc_a        (adc_a),
    .adc_b        (adc_b),
    .dac_out      (dac_out),
    .phase_inc    (phase_inc),
    .sweep_done   (sweep_done),
    .magnitude    (magnitude),
    .phase        (phase),
    .result_index (result_index),
    .mag_valid    (mag_valid)
  );

  initial
  begin
    clk125 = 1'b0;
    forever #4 clk125 = ~clk125;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_error;
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_phase_inc(input string name, input phase_inc_t got,
                                 input phase_inc_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_result(input string name, input result_t got, input result_t exp,
                              input result_t tol);
    if (got < exp - tol || got > exp + tol)
    begin
      $display("FAIL %0t %s got %0d expected %0d +/- %0d", $time, name, got, exp, tol);
      stop_on_error();
    end
  endtask

  task automatic check_index(input string name, input point_t got, input point_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // negative in the second half of each stimulus period
  task automatic check_dac_sign(input string name, input sample_t got, input logic exp_neg);
    if (got[sample_w-1] !== exp_neg)
    begin
      $display("FAIL %0t %s got %0d expected %s", $time, name, got,
               exp_neg ? "negative" : "non-negative");
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // b is a copy of a shifted in time and scaled by 2^-k
  task automatic score_point;
    result_t exp_mag;
    exp_mag = result_t'(shunt * ((1 << k) - 1));
    if (results >= num_points)
    begin
      $display("more than %0d results in one sweep at %0t", num_points, $time);
      stop_on_error();
    end
    check_index("result_index", result_index, point_t'(results));
    if (seen_inc.size() <= results)
    begin
      $display("phase_inc never stepped to point %0d before its result", results);
      stop_on_error();
    end
    check_phase_inc("phase_inc", seen_inc[results], freq_model[results]);
    check_result("phase", phase, result_t'(int'(d_b) - int'(d_a)), '0);
    check_result("magnitude", magnitude, exp_mag, exp_mag / 50 + 1);  // 2 percent, one lsb
    results++;
  endtask

  // loopback, adc_a and adc_b lag dac_out by one cycle plus their delay
  always @(posedge clk125)
  begin
    adc_a <= (d_a == 3'd0) ? dac_out : dly[d_a - 3'd1];
    adc_b <= ((d_b == 3'd0) ? dac_out : dly[d_b - 3'd1]) >>> k;
    dly[0] <= dac_out;
    for (int i = 1; i < 8; i++)
      dly[i] <= dly[i-1];
  end

  // top phase bit reaches dac_out two registers later
  always @(posedge clk125)
  begin
    if (!areset_n)
      acc_model <= '0;
    else
      acc_model <= acc_model + phase_inc;
    sign_pipe <= {sign_pipe[0], acc_model[31]};
  end

  // outputs sampled mid-cycle
  always @(negedge clk125)
  begin
    if (areset_n && seen_inc.size() != 0 && phase_inc != seen_inc[$])
      seen_inc.push_back(phase_inc);  // next point started
    if (cycles > 8)
      check_dac_sign("dac_out", dac_out, sign_pipe[1]);  // past reset and pipeline fill
    if (mag_valid)
      score_point();
  end

  always @(posedge clk125)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit)
    begin
      $display("timeout, run still busy after %0d cycles", cycles);
      stop_on_error();
    end
  end

  task automatic expect_quiet(input int n);
    repeat (n)
    begin
      @(posedge clk125);
      check_flag("mag_valid", mag_valid, 1'b0);
      check_flag("sweep_done", sweep_done, 1'b0);
    end
  endtask

  task automatic run_sweep(input int s);
    int n;
    @(posedge clk125);
    rng = xorshift32(rng);
    d_a <= rng[2:0];
    rng = xorshift32(rng);
    d_b <= rng[2:0];
    rng = xorshift32(rng);
    k <= 2'(rng % 3);
    repeat (8) @(posedge clk125);  // delay line refills
    $display("sweep %0d d_a %0d d_b %0d k %0d", s, d_a, d_b, k);
    results = 0;
    seen_inc.delete();
    seen_inc.push_back(phase_inc);  // point 0 entry
    start <= 1'b1;
    while (results < num_points)
      @(posedge clk125);
    check_flag("sweep_done", sweep_done, 1'b1);
    repeat (12)
    begin
      @(posedge clk125);
      check_flag("sweep_done", sweep_done, 1'b1);  // held with start
    end
    start <= 1'b0;
    n = 0;
    while (sweep_done && n < 4)
    begin
      @(posedge clk125);
      n++;
    end
    check_flag("sweep_done", sweep_done, 1'b0);
  endtask

  initial
  begin
    longint pmax;
    longint period;
    rng = 32'h6025;
    results = 0;
    $readmemh(freq_file, freq_model);
    pmax = 0;
    for (int i = 0; i < num_points; i++)
    begin
      period = ((longint'(1) << 32) / longint'(freq_model[i])) + 1;  // rounded up
      if (period > pmax)
        pmax = period;
    end
    limit = int'((num_points * (settle_cycles + meas_cycles + 3) * pmax + div_latency)
                 * num_sweeps) + 500;  // plus reset and gaps between sweeps
    repeat (3) @(posedge clk125);
    areset_n <= 1'b1;
    expect_quiet(20);
    for (int s = 0; s < num_sweeps; s++)
      run_sweep(s);
    repeat (4) @(posedge clk125);
    if (dut0.u_chk.fail_count != 0)
    begin
      $display("%0d assertion failures in the bound checker", dut0.u_chk.fail_count);
      stop_on_error();
    end
    else
    begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb_impedance_chk.sv ====
`default_nettype none

module tb_impedance_chk (
  input logic            clk125,
  input logic            areset_n,
  input logic            start,
  input logic            sweep_done,
  input logic            mag_valid,
  input imp_pkg::point_t result_index
);
  import imp_pkg::*;

  int fail_count = 0;  // read by the testbench at the end of the run

  // one result per pulse
  pulse_single: assert property (@(posedge clk125) disable iff (!areset_n)
    mag_valid |=> !mag_valid)
    else
    begin
      $error("mag_valid high on two consecutive cycles");
      fail_count++;
    end

  // index loaded and in the table
  index_range: assert property (@(posedge clk125) disable iff (!areset_n)
    mag_valid |-> !$isunknown(result_index) && int'(result_index) < num_points)
    else
    begin
      $error("result_index unknown or out of range at mag_valid");
      fail_count++;
    end

  // done is held until the request is withdrawn
  done_release: assert property (@(posedge clk125) disable iff (!areset_n)
    $fell(sweep_done) |-> !$past(start))
    else
    begin
      $error("sweep_done dropped while start was high");
      fail_count++;
    end

endmodule

bind impedance_sweep_top tb_impedance_chk u_chk (
  .clk125       (clk125),
  .areset_n     (areset_n),
  .start        (start),
  .sweep_done   (sweep_done),
  .mag_valid    (mag_valid),
  .result_index (result_index)
);

`default_nettype wire

// ==== zero_cross_det.sv ====
`default_nettype none

module zero_cross_det (
  input  logic             clk125,
  input  logic             areset_n,
  input  imp_pkg::sample_t sample,
  output imp_pkg::sample_t sample_q,
  output logic             crossing
);
  import imp_pkg::*;

  localparam int run_w = $clog2(det_width);

  typedef enum logic [1:0] {
    zc_wait,  // waiting for a non-negative sample
    zc_run,   // counting the run
    zc_armed  // run long enough
  } zc_state_t;

  zc_state_t        state;
  logic [run_w-1:0] run_cnt;
  logic             neg;

  always_ff @(posedge clk125)
    sample_q <= sample;

  assign neg = sample_q[sample_w-1];  // sign of the registered sample

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state    <= zc_wait;
      run_cnt  <= '0;
      crossing <= 1'b0;
    end
    else
    begin
      crossing <= 1'b0;  // single-cycle pulse
      case (state)
        zc_wait:
          if (!neg)
          begin
            run_cnt <= '0;  // first sample of a run
            state   <= zc_run;
          end
        zc_run:
          if (neg)
            state <= zc_wait;  // run too short, glitch or noise
          else if (run_cnt == run_w'(det_width - 1))
            state <= zc_armed;  // det_width+1 samples seen
          else
            run_cnt <= run_cnt + 1'b1;
        zc_armed:
          if (neg)
          begin
            crossing <= 1'b1;  // falling edge after a full run
            state    <= zc_wait;
          end
        default:
          state <= zc_wait;
      endcase
    end
  end

endmodule

`default_nettype wire
